/* flist.f */
prf_pkg.sv
prf_entry.sv
prf_priority_sel.sv
prf_free_select.sv
prf_release_ctrl.sv
prf_cdb_write.sv
prf_read_mux.sv
prf.sv
tb_prf.sv

/* prf.sv */
////////////////////
// physical register file top with entry array, rename, CDB, read and release
////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf
(
	input  wire                            clock,
	input  wire                            rst_n,
	// rename allocation, grant in the same cycle
	input  wire                            alloc_req1,
	input  wire                            alloc_req2,
	output logic                           rename_valid1,
	output logic                           rename_valid2,
	output logic [prf_pkg::PRF_IDX_W-1:0]  rename_idx1,
	output logic [prf_pkg::PRF_IDX_W-1:0]  rename_idx2,
	// results from the execution units
	input  wire                            cdb1_valid,
	input  wire [prf_pkg::PRF_IDX_W-1:0]   cdb1_tag,
	input  wire [prf_pkg::DATA_W-1:0]      cdb1_data,
	input  wire                            cdb2_valid,
	input  wire [prf_pkg::PRF_IDX_W-1:0]   cdb2_tag,
	input  wire [prf_pkg::DATA_W-1:0]      cdb2_data,
	// operand reads for the reservation stations
	input  wire [prf_pkg::PRF_IDX_W-1:0]   rd_idx0,
	input  wire [prf_pkg::PRF_IDX_W-1:0]   rd_idx1,
	input  wire [prf_pkg::PRF_IDX_W-1:0]   rd_idx2,
	input  wire [prf_pkg::PRF_IDX_W-1:0]   rd_idx3,
	output logic [prf_pkg::DATA_W-1:0]     rd_data0,
	output logic [prf_pkg::DATA_W-1:0]     rd_data1,
	output logic [prf_pkg::DATA_W-1:0]     rd_data2,
	output logic [prf_pkg::DATA_W-1:0]     rd_data3,
	output logic                           rd_ready0,
	output logic                           rd_ready1,
	output logic                           rd_ready2,
	output logic                           rd_ready3,
	// frees from the ROB and the retirement map
	input  wire                            retire1_valid,
	input  wire [prf_pkg::PRF_IDX_W-1:0]   retire1_idx,
	input  wire                            retire2_valid,
	input  wire [prf_pkg::PRF_IDX_W-1:0]   retire2_idx,
	input  wire                            branch_recover,     // mispredict recovery cycle
	input  wire [prf_pkg::PRF_SIZE-1:0]    recover_free_list   // entries the retirement map does not hold
);

	prf_pkg::prf_state_e                              entry_state [prf_pkg::PRF_SIZE];
	logic [prf_pkg::PRF_SIZE-1:0][prf_pkg::DATA_W-1:0] entry_data;
	logic [prf_pkg::PRF_SIZE-1:0]                     free_vec;     // state views of the array
	logic [prf_pkg::PRF_SIZE-1:0]                     pending_vec;
	logic [prf_pkg::PRF_SIZE-1:0]                     ready_vec;
	logic [prf_pkg::PRF_SIZE-1:0]                     alloc_gnt1;
	logic [prf_pkg::PRF_SIZE-1:0]                     alloc_gnt2;
	logic [prf_pkg::PRF_SIZE-1:0]                     release_vec;
	logic [prf_pkg::PRF_SIZE-1:0]                     write_en_vec;
	logic [prf_pkg::PRF_SIZE-1:0][prf_pkg::DATA_W-1:0] write_data_vec;

	////////////////////
	// entry array
	////////////////////
	for (genvar i = 0; i < prf_pkg::PRF_SIZE; i++)
	begin : g_entry
		prf_entry entry_i
		(
			.clock      (clock),
			.rst_n      (rst_n),
			.release_en (release_vec[i]),
			.alloc      (alloc_gnt1[i] | alloc_gnt2[i]),  // either rename slot may take it
			.write_en   (write_en_vec[i]),
			.write_data (write_data_vec[i]),
			.state      (entry_state[i]),
			.data       (entry_data[i])
		);

		assign free_vec[i]    = (entry_state[i] == prf_pkg::PRF_FREE);
		assign pending_vec[i] = (entry_state[i] == prf_pkg::PRF_PENDING);
		assign ready_vec[i]   = (entry_state[i] == prf_pkg::PRF_READY);
	end

	////////////////////
	// control blocks, all combinational around the array
	////////////////////
	prf_free_select free_select_i
	(
		.free_vec       (free_vec),
		.alloc_req1     (alloc_req1),
		.alloc_req2     (alloc_req2),
		.branch_recover (branch_recover),
		.alloc_gnt1     (alloc_gnt1),
		.alloc_gnt2     (alloc_gnt2),
		.rename_valid1  (rename_valid1),
		.rename_valid2  (rename_valid2),
		.rename_idx1    (rename_idx1),
		.rename_idx2    (rename_idx2)
	);

	prf_release_ctrl release_ctrl_i
	(
		.retire1_valid     (retire1_valid),
		.retire1_idx       (retire1_idx),
		.retire2_valid     (retire2_valid),
		.retire2_idx       (retire2_idx),
		.branch_recover    (branch_recover),
		.recover_free_list (recover_free_list),
		.release_vec       (release_vec)
	);

	prf_cdb_write cdb_write_i
	(
		.cdb1_valid     (cdb1_valid),
		.cdb1_tag       (cdb1_tag),
		.cdb1_data      (cdb1_data),
		.cdb2_valid     (cdb2_valid),
		.cdb2_tag       (cdb2_tag),
		.cdb2_data      (cdb2_data),
		.pending_vec    (pending_vec),
		.write_en_vec   (write_en_vec),
		.write_data_vec (write_data_vec)
	);

	prf_read_mux read_mux_i
	(
		.entry_data     (entry_data),
		.ready_vec      (ready_vec),
		.write_en_vec   (write_en_vec),    // shared with the entries for the bypass
		.write_data_vec (write_data_vec),
		.rd_idx0        (rd_idx0),
		.rd_idx1        (rd_idx1),
		.rd_idx2        (rd_idx2),
		.rd_idx3        (rd_idx3),
		.rd_data0       (rd_data0),
		.rd_data1       (rd_data1),
		.rd_data2       (rd_data2),
		.rd_data3       (rd_data3),
		.rd_ready0      (rd_ready0),
		.rd_ready1      (rd_ready1),
		.rd_ready2      (rd_ready2),
		.rd_ready3      (rd_ready3)
	);

endmodule

`default_nettype wire

/* prf_cdb_write.sv */
////////////////////
// decodes the two CDB tags into per-entry write enables and write data
////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf_cdb_write
(
	input  wire                                              cdb1_valid,
	input  wire [prf_pkg::PRF_IDX_W-1:0]                     cdb1_tag,
	input  wire [prf_pkg::DATA_W-1:0]                        cdb1_data,
	input  wire                                              cdb2_valid,
	input  wire [prf_pkg::PRF_IDX_W-1:0]                     cdb2_tag,
	input  wire [prf_pkg::DATA_W-1:0]                        cdb2_data,
	input  wire [prf_pkg::PRF_SIZE-1:0]                      pending_vec,  // entries waiting for a result
	output logic [prf_pkg::PRF_SIZE-1:0]                     write_en_vec,
	output logic [prf_pkg::PRF_SIZE-1:0][prf_pkg::DATA_W-1:0] write_data_vec
);

	// a bus only writes an entry that is pending, results for free or
	// ready entries are dropped here
	always_comb
	begin
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
		begin
			write_en_vec[i]   = 1'b0;
			write_data_vec[i] = '0;
			if (pending_vec[i] && cdb1_valid && (cdb1_tag == i[prf_pkg::PRF_IDX_W-1:0]))
			begin
				write_en_vec[i]   = 1'b1;  // cdb1 is checked first so it wins a tie
				write_data_vec[i] = cdb1_data;
			end
			else if (pending_vec[i] && cdb2_valid && (cdb2_tag == i[prf_pkg::PRF_IDX_W-1:0]))
			begin
				write_en_vec[i]   = 1'b1;
				write_data_vec[i] = cdb2_data;
			end
		end
	end

	////////////////////
	// each physical register has one producer, so the execution units
	// never broadcast the same tag on both buses
	always_comb
	begin
		assert final (!(cdb1_valid && cdb2_valid && (cdb1_tag == cdb2_tag)))
			else $error("prf_cdb_write: both CDBs carry tag %0d", cdb1_tag);
	end

endmodule

`default_nettype wire

/* prf_entry.sv */
////////////////////
// one physical register with its state and 64-bit value
////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf_entry
(
	input  wire                          clock,
	input  wire                          rst_n,
	input  wire                          release_en,  // retire or recovery frees this entry
	input  wire                          alloc,       // rename grant for this entry
	input  wire                          write_en,    // CDB result for this entry
	input  wire [prf_pkg::DATA_W-1:0]    write_data,
	output prf_pkg::prf_state_e          state,
	output logic [prf_pkg::DATA_W-1:0]   data
);

	// release wins over allocation, and allocation wins over a CDB write
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= prf_pkg::PRF_FREE;
			data  <= '0;
		end
		else if (release_en)
		begin
			state <= prf_pkg::PRF_FREE;  // a freed entry forgets its old value
			data  <= '0;
		end
		else if (alloc)
		begin
			state <= prf_pkg::PRF_PENDING;  // value stays as it was until the CDB writes
		end
		else if (write_en)
		begin
			state <= prf_pkg::PRF_READY;
			data  <= write_data;
		end
	end

	////////////////////
	// checks on the control blocks that drive this entry
	////////////////////

	// the free selector must only grant what the free vector shows
	assert property (@(posedge clock) disable iff (!rst_n)
		alloc |-> (state == prf_pkg::PRF_FREE))
		else $error("prf_entry: alloc seen while the entry is not free");

	// the CDB decoder must only write entries that wait for a result
	assert property (@(posedge clock) disable iff (!rst_n)
		write_en |-> (state == prf_pkg::PRF_PENDING))
		else $error("prf_entry: write_en seen while the entry is not pending");

endmodule

`default_nettype wire

/* prf_free_select.sv */
////////////////////
// picks the two rename registers from the free vector and encodes them
////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf_free_select
(
	input  wire [prf_pkg::PRF_SIZE-1:0]    free_vec,        // entries in PRF_FREE
	input  wire                            alloc_req1,      // rename slot 1 wants a register
	input  wire                            alloc_req2,      // rename slot 2 wants a register
	input  wire                            branch_recover,  // no grants in a recovery cycle
	output logic [prf_pkg::PRF_SIZE-1:0]   alloc_gnt1,
	output logic [prf_pkg::PRF_SIZE-1:0]   alloc_gnt2,
	output logic                           rename_valid1,
	output logic                           rename_valid2,
	output logic [prf_pkg::PRF_IDX_W-1:0]  rename_idx1,
	output logic [prf_pkg::PRF_IDX_W-1:0]  rename_idx2
);

	logic [prf_pkg::PRF_SIZE-1:0] free_vec2;  // free entries left for slot 2

	// one-hot to binary, an empty vector gives index zero
	function automatic logic [prf_pkg::PRF_IDX_W-1:0] encode
	(
		input logic [prf_pkg::PRF_SIZE-1:0] onehot
	);
		logic [prf_pkg::PRF_IDX_W-1:0] idx;
		idx = '0;
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
		begin
			if (onehot[i])
			begin
				idx = idx | i[prf_pkg::PRF_IDX_W-1:0];
			end
		end
		return idx;
	endfunction

	// slot 1 has priority and takes the lowest free register
	prf_priority_sel sel1_i
	(
		.req (free_vec),
		.en  (alloc_req1 && !branch_recover),
		.gnt (alloc_gnt1)
	);

	assign free_vec2 = free_vec & ~alloc_gnt1;  // slot 1's pick is gone for slot 2

	prf_priority_sel sel2_i
	(
		.req (free_vec2),
		.en  (alloc_req2 && !branch_recover),
		.gnt (alloc_gnt2)
	);

	assign rename_valid1 = |alloc_gnt1;  // a slot with no grant stalls and retries
	assign rename_valid2 = |alloc_gnt2;
	assign rename_idx1   = encode(alloc_gnt1);
	assign rename_idx2   = encode(alloc_gnt2);

	// both slots must never rename to the same physical register
	always_comb
	begin
		assert final ((alloc_gnt1 & alloc_gnt2) == '0)
			else $error("prf_free_select: both rename slots granted one entry");
	end

endmodule

`default_nettype wire

/* prf_pkg.sv */
////////////////////
// register file sizes and the state enum of one physical register
////////////////////
`default_nettype none

package prf_pkg;

	localparam int PRF_SIZE  = 32;                // physical registers in the file
	localparam int PRF_IDX_W = $clog2(PRF_SIZE);  // width of a physical register index
	localparam int DATA_W    = 64;                // width of one register value

	// lifecycle of one physical register, rename moves it out of free and
	// retire or recovery brings it back
	typedef enum logic [1:0]
	{
		PRF_FREE    = 2'b00,  // not allocated, rename may hand it out
		PRF_PENDING = 2'b01,  // allocated, its result has not been on the CDB yet
		PRF_READY   = 2'b10   // holds a valid result for the operand reads
	} prf_state_e;

endpackage

`default_nettype wire

/* prf_priority_sel.sv */
////////////////////
// lowest-index one-hot grant with enable
////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf_priority_sel
(
	input  wire [prf_pkg::PRF_SIZE-1:0]   req,  // one bit per requesting entry
	input  wire                           en,   // low forces an empty grant
	output logic [prf_pkg::PRF_SIZE-1:0]  gnt
);

	logic [prf_pkg::PRF_SIZE-1:0] lowest;  // lowest set bit of req

	// two's complement keeps only the lowest set bit and zero stays zero
	assign lowest = req & (~req + 1'b1);

	always_comb
	begin
		if (en)
		begin
			gnt = lowest;
		end
		else
		begin
			gnt = '0;
		end
	end

endmodule

`default_nettype wire

/* prf_read_mux.sv */
////////////////////
// four operand read ports with CDB bypass and ready flags
////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf_read_mux
(
	input  wire [prf_pkg::PRF_SIZE-1:0][prf_pkg::DATA_W-1:0] entry_data,      // stored values
	input  wire [prf_pkg::PRF_SIZE-1:0]                      ready_vec,       // entries in PRF_READY
	input  wire [prf_pkg::PRF_SIZE-1:0]                      write_en_vec,    // CDB writes this cycle
	input  wire [prf_pkg::PRF_SIZE-1:0][prf_pkg::DATA_W-1:0] write_data_vec,
	input  wire [prf_pkg::PRF_IDX_W-1:0]                     rd_idx0,
	input  wire [prf_pkg::PRF_IDX_W-1:0]                     rd_idx1,
	input  wire [prf_pkg::PRF_IDX_W-1:0]                     rd_idx2,
	input  wire [prf_pkg::PRF_IDX_W-1:0]                     rd_idx3,
	output logic [prf_pkg::DATA_W-1:0]                       rd_data0,
	output logic [prf_pkg::DATA_W-1:0]                       rd_data1,
	output logic [prf_pkg::DATA_W-1:0]                       rd_data2,
	output logic [prf_pkg::DATA_W-1:0]                       rd_data3,
	output logic                                             rd_ready0,
	output logic                                             rd_ready1,
	output logic                                             rd_ready2,
	output logic                                             rd_ready3
);

	logic [prf_pkg::PRF_IDX_W-1:0] rd_idx   [4];  // ports gathered for one loop
	logic [prf_pkg::DATA_W-1:0]    rd_data  [4];
	logic                          rd_ready [4];

	assign rd_idx[0] = rd_idx0;
	assign rd_idx[1] = rd_idx1;
	assign rd_idx[2] = rd_idx2;
	assign rd_idx[3] = rd_idx3;

	// the write enables already hold the tag match and cdb1 priority
	always_comb
	begin
		for (int p = 0; p < 4; p++)
		begin
			if (write_en_vec[rd_idx[p]])
			begin
				rd_data[p]  = write_data_vec[rd_idx[p]];  // bypass the result landing this cycle
				rd_ready[p] = 1'b1;
			end
			else if (ready_vec[rd_idx[p]])
			begin
				rd_data[p]  = entry_data[rd_idx[p]];
				rd_ready[p] = 1'b1;
			end
			else
			begin
				rd_data[p]  = '0;  // not available yet, the consumer waits on the CDB
				rd_ready[p] = 1'b0;
			end
		end
	end

	assign rd_data0  = rd_data[0];
	assign rd_data1  = rd_data[1];
	assign rd_data2  = rd_data[2];
	assign rd_data3  = rd_data[3];
	assign rd_ready0 = rd_ready[0];
	assign rd_ready1 = rd_ready[1];
	assign rd_ready2 = rd_ready[2];
	assign rd_ready3 = rd_ready[3];

endmodule

`default_nettype wire

/* prf_release_ctrl.sv */
////////////////////
// per-entry release from the two retire frees and mispredict recovery
////////////////////
`timescale 1ns/1ps
`default_nettype none

module prf_release_ctrl
(
	input  wire                            retire1_valid,      // first retiring instruction frees a register
	input  wire [prf_pkg::PRF_IDX_W-1:0]   retire1_idx,
	input  wire                            retire2_valid,      // second retiring instruction
	input  wire [prf_pkg::PRF_IDX_W-1:0]   retire2_idx,
	input  wire                            branch_recover,     // mispredict flush this cycle
	input  wire [prf_pkg::PRF_SIZE-1:0]    recover_free_list,  // 1 marks an entry to free on recovery
	output logic [prf_pkg::PRF_SIZE-1:0]   release_vec
);

	logic [prf_pkg::PRF_SIZE-1:0] retire_vec;  // decoded retire frees

	// decode both retire indices into one vector
	always_comb
	begin
		retire_vec = '0;
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
		begin
			if (retire1_valid && (retire1_idx == i[prf_pkg::PRF_IDX_W-1:0]))
			begin
				retire_vec[i] = 1'b1;
			end
			if (retire2_valid && (retire2_idx == i[prf_pkg::PRF_IDX_W-1:0]))
			begin
				retire_vec[i] = 1'b1;
			end
		end
	end

	// the recovery list only counts while branch_recover is high
	assign release_vec = retire_vec | (branch_recover ? recover_free_list : '0);

	////////////////////
	// the ROB retires two distinct architectural writes, so their old
	// physical registers cannot be the same
	always_comb
	begin
		assert final (!(retire1_valid && retire2_valid && (retire1_idx == retire2_idx)))
			else $error("prf_release_ctrl: both retires free entry %0d", retire1_idx);
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the register file testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_prf -f flist.f
./obj_dir/Vtb_prf | tee sim.log
if grep -q "ALL TESTS PASSED" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* tb_prf.sv */
////////////////////
// testbench for the physical register file with a reference model, a checker and a watchdog
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_prf;

	logic                           clock;
	logic                           rst_n;
	logic                           alloc_req1, alloc_req2;
	logic                           rename_valid1, rename_valid2;
	logic [prf_pkg::PRF_IDX_W-1:0]  rename_idx1, rename_idx2;
	logic                           cdb1_valid, cdb2_valid;
	logic [prf_pkg::PRF_IDX_W-1:0]  cdb1_tag, cdb2_tag;
	logic [prf_pkg::DATA_W-1:0]     cdb1_data, cdb2_data;
	logic [prf_pkg::PRF_IDX_W-1:0]  rd_idx0, rd_idx1, rd_idx2, rd_idx3;
	logic [prf_pkg::DATA_W-1:0]     rd_data0, rd_data1, rd_data2, rd_data3;
	logic                           rd_ready0, rd_ready1, rd_ready2, rd_ready3;
	logic                           retire1_valid, retire2_valid;
	logic [prf_pkg::PRF_IDX_W-1:0]  retire1_idx, retire2_idx;
	logic                           branch_recover;
	logic [prf_pkg::PRF_SIZE-1:0]   recover_free_list;

	integer seed = 32'h6b93_0015;  // one fixed seed so every run sees the same random mix
	int     error_count = 0;
	int     test_start_errors = 0;  // errors seen before the running test began
	int     tests_run = 0;
	int     tests_failed = 0;
	int     directed_cycles = 40;   // upper bound of the directed tests with their idle cycles
	int     random_cycles = 400;

	// reference copy of the entry array, it always holds the state after the next edge
	prf_pkg::prf_state_e        model_state [prf_pkg::PRF_SIZE];
	logic [prf_pkg::DATA_W-1:0] model_data  [prf_pkg::PRF_SIZE];

	prf dut_i (.*);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;  // 8 ns period
	end

	////////////////////
	// reference model
	////////////////////

	// lowest free entry other than skip, -1 when none is left
	function automatic int lowest_free(input int skip);
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
		begin
			if (model_state[i] == prf_pkg::PRF_FREE && i != skip)
			begin
				return i;
			end
		end
		return -1;
	endfunction

	// top bit is the ready flag, the rest is the data a read port should show
	function automatic logic [prf_pkg::DATA_W:0] expected_read(input int idx);
		if (model_state[idx] == prf_pkg::PRF_PENDING && cdb1_valid && int'(cdb1_tag) == idx)
		begin
			return {1'b1, cdb1_data};  // bypass, cdb1 first
		end
		if (model_state[idx] == prf_pkg::PRF_PENDING && cdb2_valid && int'(cdb2_tag) == idx)
		begin
			return {1'b1, cdb2_data};
		end
		if (model_state[idx] == prf_pkg::PRF_READY)
		begin
			return {1'b1, model_data[idx]};
		end
		return '0;
	endfunction

	// applies release, then allocation, then the CDB write to every entry
	function automatic void advance_model(input int gnt1, input int gnt2);
		logic release_hit;
		logic hit1;
		logic hit2;
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
		begin
			release_hit = (retire1_valid && int'(retire1_idx) == i)
				|| (retire2_valid && int'(retire2_idx) == i)
				|| (branch_recover && recover_free_list[i]);
			hit1 = cdb1_valid && int'(cdb1_tag) == i;
			hit2 = cdb2_valid && int'(cdb2_tag) == i;
			if (release_hit)
			begin
				model_state[i] = prf_pkg::PRF_FREE;
				model_data[i]  = '0;
			end
			else if (i == gnt1 || i == gnt2)
			begin
				model_state[i] = prf_pkg::PRF_PENDING;
			end
			else if (model_state[i] == prf_pkg::PRF_PENDING && (hit1 || hit2))
			begin
				model_state[i] = prf_pkg::PRF_READY;
				model_data[i]  = hit1 ? cdb1_data : cdb2_data;
			end
		end
	endfunction

	function automatic logic [prf_pkg::PRF_SIZE-1:0] state_mask(input prf_pkg::prf_state_e st);
		logic [prf_pkg::PRF_SIZE-1:0] mask;
		mask = '0;
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
		begin
			mask[i] = (model_state[i] == st);
		end
		return mask;
	endfunction

	// random set bit of mask other than skip, -1 when there is none
	function automatic int pick_entry(input logic [prf_pkg::PRF_SIZE-1:0] mask, input int skip);
		int count;
		int k;
		count = 0;
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
		begin
			if (mask[i] && i != skip)
			begin
				count++;
			end
		end
		if (count == 0)
		begin
			return -1;
		end
		k = $unsigned($random(seed)) % count;
		for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
		begin
			if (mask[i] && i != skip)
			begin
				if (k == 0)
				begin
					return i;
				end
				k--;
			end
		end
		return -1;
	endfunction

	function automatic void check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected)
		else
		begin
			$display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
			error_count++;
		end
	endfunction

	////////////////////
	// checker, runs mid-cycle where every DUT output has settled
	////////////////////
	always @(negedge clock)
	begin : compare_outputs
		int                            gnt1;
		int                            gnt2;
		logic [prf_pkg::DATA_W:0]      exp_rd;
		logic [prf_pkg::PRF_IDX_W-1:0] idx [4];
		logic [prf_pkg::DATA_W-1:0]    act_data [4];
		logic                          act_ready [4];
		if (!rst_n)
		begin
			for (int i = 0; i < prf_pkg::PRF_SIZE; i++)
			begin
				model_state[i] = prf_pkg::PRF_FREE;
				model_data[i]  = '0;
			end
		end
		else
		begin
			gnt1 = (alloc_req1 && !branch_recover) ? lowest_free(-1) : -1;
			gnt2 = (alloc_req2 && !branch_recover) ? lowest_free(gnt1) : -1;  // slot 2 skips slot 1
			check_value("rename_valid1", gnt1 >= 0, rename_valid1);
			check_value("rename_valid2", gnt2 >= 0, rename_valid2);
			if (gnt1 >= 0)
			begin
				check_value("rename_idx1", gnt1, rename_idx1);
			end
			if (gnt2 >= 0)
			begin
				check_value("rename_idx2", gnt2, rename_idx2);
			end
			idx       = '{rd_idx0, rd_idx1, rd_idx2, rd_idx3};
			act_data  = '{rd_data0, rd_data1, rd_data2, rd_data3};
			act_ready = '{rd_ready0, rd_ready1, rd_ready2, rd_ready3};
			for (int p = 0; p < 4; p++)
			begin
				exp_rd = expected_read(int'(idx[p]));
				check_value($sformatf("rd_ready%0d", p), exp_rd[prf_pkg::DATA_W], act_ready[p]);
				check_value($sformatf("rd_data%0d", p), exp_rd[prf_pkg::DATA_W-1:0], act_data[p]);
			end
			advance_model(gnt1, gnt2);  // the DUT takes the same inputs at the next edge
		end
	end

	////////////////////
	// stimulus helpers
	////////////////////
	task automatic clear_inputs();
		alloc_req1        <= 1'b0;
		alloc_req2        <= 1'b0;
		cdb1_valid        <= 1'b0;
		cdb1_tag          <= '0;
		cdb1_data         <= '0;
		cdb2_valid        <= 1'b0;
		cdb2_tag          <= '0;
		cdb2_data         <= '0;
		rd_idx0           <= '0;
		rd_idx1           <= '0;
		rd_idx2           <= '0;
		rd_idx3           <= '0;
		retire1_valid     <= 1'b0;
		retire1_idx       <= '0;
		retire2_valid     <= 1'b0;
		retire2_idx       <= '0;
		branch_recover    <= 1'b0;
		recover_free_list <= '0;
	endtask

	// idle inputs for the coming cycle, the caller overrides what it needs
	task automatic next_cycle();
		@(posedge clock);
		clear_inputs();
	endtask

	task automatic finish_test(input string name);
		next_cycle();  // the checker has seen the last stimulus by now
		tests_run++;
		if (error_count != test_start_errors)
		begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", tests_run, name,
				error_count - test_start_errors);
		end
		else
		begin
			$display("test %0d %s: ok", tests_run, name);
		end
		test_start_errors = error_count;
	endtask

	// legal random traffic drawn from what the model holds after this edge
	task automatic drive_random_cycle();
		logic [31:0] r;
		int          t1;
		int          t2;
		int          r1;
		int          r2;
		next_cycle();
		r  = $random(seed);
		t1 = pick_entry(state_mask(prf_pkg::PRF_PENDING), -1);
		t2 = pick_entry(state_mask(prf_pkg::PRF_PENDING), t1);  // never the same tag twice
		r1 = pick_entry(~state_mask(prf_pkg::PRF_FREE), -1);
		r2 = pick_entry(~state_mask(prf_pkg::PRF_FREE), r1);
		alloc_req1 <= r[0];
		alloc_req2 <= r[1];
		cdb1_valid <= (r[3:2] != 2'b00) && t1 >= 0;
		cdb1_tag   <= t1[prf_pkg::PRF_IDX_W-1:0];
		cdb1_data  <= {$random(seed), $random(seed)};
		cdb2_valid <= (r[5:4] != 2'b00) && t2 >= 0;
		cdb2_tag   <= t2[prf_pkg::PRF_IDX_W-1:0];
		cdb2_data  <= {$random(seed), $random(seed)};
		retire1_valid <= (r[7:6] == 2'b00) && r1 >= 0;
		retire1_idx   <= r1[prf_pkg::PRF_IDX_W-1:0];
		retire2_valid <= (r[9:8] == 2'b00) && r2 >= 0;
		retire2_idx   <= r2[prf_pkg::PRF_IDX_W-1:0];
		branch_recover    <= (r[14:10] == 5'd0);  // about one cycle in 32
		recover_free_list <= $random(seed) & $random(seed);
		rd_idx0 <= (t1 >= 0) ? t1[prf_pkg::PRF_IDX_W-1:0] : r[19:15];  // aims at the bypass
		rd_idx1 <= r[24:20];
		rd_idx2 <= r[29:25];
		rd_idx3 <= (t2 >= 0) ? t2[prf_pkg::PRF_IDX_W-1:0] : r[4:0];
	endtask

	////////////////////
	// test sequence
	////////////////////
	initial
	begin
		rst_n <= 1'b0;
		clear_inputs();
		repeat (5) @(posedge clock);
		rst_n <= 1'b1;

		for (int i = 0; i < 18; i++)  // 16 pairs fill the file, two more must stall
		begin
			next_cycle();
			alloc_req1 <= 1'b1;
			alloc_req2 <= 1'b1;
			rd_idx0    <= 5'(2 * i);
		end
		finish_test("allocation and exhaustion");

		next_cycle();
		cdb1_valid <= 1'b1;
		cdb1_tag   <= 5'd5;
		cdb1_data  <= 64'h0123_4567_89ab_cdef;
		rd_idx0    <= 5'd5;
		next_cycle();
		rd_idx0    <= 5'd5;
		cdb1_valid <= 1'b1;
		cdb1_tag   <= 5'd6;
		cdb1_data  <= 64'hdead_beef_0000_0006;
		cdb2_valid <= 1'b1;
		cdb2_tag   <= 5'd7;
		cdb2_data  <= 64'hcafe_f00d_0000_0007;
		rd_idx1    <= 5'd6;
		rd_idx2    <= 5'd7;
		next_cycle();
		rd_idx1    <= 5'd6;
		rd_idx2    <= 5'd7;
		rd_idx3    <= 5'd5;
		finish_test("cdb write and read");

		next_cycle();
		retire1_valid <= 1'b1;
		retire1_idx   <= 5'd9;
		next_cycle();
		cdb1_valid <= 1'b1;  // entry 9 is free now
		cdb1_tag   <= 5'd9;
		cdb1_data  <= 64'h5555_aaaa_5555_aaaa;
		cdb2_valid <= 1'b1;  // entry 5 is already ready
		cdb2_tag   <= 5'd5;
		cdb2_data  <= 64'h1111_2222_3333_4444;
		rd_idx0    <= 5'd9;
		rd_idx1    <= 5'd5;
		next_cycle();
		rd_idx0    <= 5'd9;
		rd_idx1    <= 5'd5;
		finish_test("ignored writes");

		next_cycle();
		retire1_valid <= 1'b1;
		retire1_idx   <= 5'd3;
		retire2_valid <= 1'b1;
		retire2_idx   <= 5'd20;
		next_cycle();
		alloc_req1 <= 1'b1;  // 3 and 9 are the lowest free entries
		alloc_req2 <= 1'b1;
		next_cycle();
		alloc_req1 <= 1'b1;
		alloc_req2 <= 1'b1;
		finish_test("retire free");

		next_cycle();
		branch_recover    <= 1'b1;
		recover_free_list <= 32'h0f0f_00f0;
		alloc_req1        <= 1'b1;
		alloc_req2        <= 1'b1;
		next_cycle();
		rd_idx0    <= 5'd4;
		rd_idx1    <= 5'd16;
		rd_idx2    <= 5'd24;
		rd_idx3    <= 5'd7;
		alloc_req1 <= 1'b1;
		alloc_req2 <= 1'b1;
		finish_test("mispredict recovery");

		repeat (random_cycles) drive_random_cycle();
		finish_test("random mix");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// reset, the directed and random cycles, and a margin for the idle cycles
	initial
	begin
		repeat (5 + directed_cycles + random_cycles + 100) @(posedge clock);
		$display("watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
